//--- Makefile
# Verilator build and run for the grid receive path

VERILATOR ?= verilator
TB_TOP    ?= grid_rx_tb
RTL_TOP   ?= grid_rx_top
FILELIST  ?= grid_rx_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS
RTL_SRCS  ?= $(shell grep '^rtl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/grid_rx_checker.sv
/*
 * Stream protocol checker
 * Bound into grid_rx_top. Mirrors the occupancy of both FIFOs from their
 * push and pop strobes and checks the flags of the DMA stream.
 */
module grid_rx_checker (
    input logic clk_i,
    input logic reset_ni,
    input logic grid_wr_i,
    input logic grid_ack_i,
    input logic grid_valid_i,
    input logic id_wr_i,
    input logic id_ack_i,
    input logic id_valid_i,
    input logic dma_tvalid_i,
    input logic dma_tready_i,
    input logic dma_tlast_i,
    input logic overflow_i,
    input logic int_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int grid_count;
    int id_count;

    // a push into a full FIFO is lost, a pop needs a valid head
    function automatic int next_count(int count, int depth, logic push, logic pop);
        int n;
        n = count;
        if (push && count < depth) begin
            n = n + 1;
        end
        if (pop) begin
            n = n - 1;
        end
        return n;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            grid_count <= 0;
            id_count   <= 0;
        end else begin
            grid_count <= next_count(grid_count, nr_grid_pkg::GRID_FIFO_DEPTH, grid_wr_i,
                                     grid_ack_i && grid_valid_i);
            id_count   <= next_count(id_count, nr_grid_pkg::ID_FIFO_DEPTH, id_wr_i,
                                     id_ack_i && id_valid_i);
        end
    end

    grid_no_overrun: assert property (@(posedge clk_i) disable iff (!reset_ni)
        grid_wr_i |-> grid_count < nr_grid_pkg::GRID_FIFO_DEPTH)
        else $error("grid FIFO written while full");

    id_no_overrun: assert property (@(posedge clk_i) disable iff (!reset_ni)
        id_wr_i |-> id_count < nr_grid_pkg::ID_FIFO_DEPTH)
        else $error("timestamp FIFO written while full");

    int_with_last: assert property (@(posedge clk_i) disable iff (!reset_ni)
        int_i |-> dma_tlast_i)
        else $error("int_o raised without dma_tlast_o");

    last_with_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        dma_tlast_i |-> dma_tvalid_i)
        else $error("dma_tlast_o raised without dma_tvalid_o");

    overflow_after_drop: assert property (@(posedge clk_i) disable iff (!reset_ni)
        overflow_i |-> $past(dma_tvalid_i && !dma_tready_i))
        else $error("overflow_o without a word offered while not ready");

endmodule

//--- bench/grid_rx_tb.sv
/*
 * Testbench for the grid receive path
 * Drives demodulator samples into grid_rx_top, predicts the DMA word
 * stream from the packet format and compares every word offered.
 */
module grid_rx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SYMBOLS_SENT = 10;
    localparam int WATCHDOG_CYCLES = 400 * SYMBOLS_SENT + 1000;

    logic                                clk_i;
    logic                                reset_ni;
    logic [nr_grid_pkg::IQ_WIDTH-1:0]    iq_data_i;
    logic                                iq_valid_i;
    logic [nr_grid_pkg::BLK_EXP_LEN-1:0] blk_exp_i;
    logic                                dma_tready_i;
    logic [nr_grid_pkg::IQ_WIDTH-1:0]    dma_tdata_o;
    logic                                dma_tvalid_o;
    logic                                dma_tlast_o;
    logic                                overflow_o;
    logic                                int_o;

    // predicted stream
    logic [nr_grid_pkg::IQ_WIDTH-1:0] exp_data_q[$];
    logic                             exp_last_q[$];
    // every word offered by the DUT, with the ready seen alongside
    logic [nr_grid_pkg::IQ_WIDTH-1:0] got_data_q[$];
    logic                             got_last_q[$];
    logic                             got_int_q[$];
    logic                             got_ready_q[$];

    logic [dma_stream_pkg::SAMPLE_ID_WIDTH-1:0] stim_idx;
    int overflow_cnt;
    int seed = 2;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    grid_rx_top dut (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .iq_data_i    (iq_data_i),
        .iq_valid_i   (iq_valid_i),
        .blk_exp_i    (blk_exp_i),
        .dma_tready_i (dma_tready_i),
        .dma_tdata_o  (dma_tdata_o),
        .dma_tvalid_o (dma_tvalid_o),
        .dma_tlast_o  (dma_tlast_o),
        .overflow_o   (overflow_o),
        .int_o        (int_o)
    );

    bind grid_rx_top grid_rx_checker protocol_check (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .grid_wr_i    (grid_wr),
        .grid_ack_i   (grid_ack),
        .grid_valid_i (grid_valid),
        .id_wr_i      (id_wr),
        .id_ack_i     (id_ack),
        .id_valid_i   (id_valid),
        .dma_tvalid_i (dma_tvalid_o),
        .dma_tready_i (dma_tready_i),
        .dma_tlast_i  (dma_tlast_o),
        .overflow_i   (overflow_o),
        .int_i        (int_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired before all tests finished, the DMA stream stalled");
        $display("STATUS: FAIL");
        $finish;
    end

    // outputs are sampled mid-cycle, away from the clock edge
    always @(negedge clk_i) begin
        if (dma_tvalid_o) begin
            got_data_q.push_back(dma_tdata_o);
            got_last_q.push_back(dma_tlast_o);
            got_int_q.push_back(int_o);
            got_ready_q.push_back(dma_tready_i);
        end
        if (overflow_o) begin
            overflow_cnt++;
        end
    end

    task automatic compare_word(input string name, input logic [nr_grid_pkg::IQ_WIDTH-1:0] got,
                                input logic [nr_grid_pkg::IQ_WIDTH-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    task automatic clear_model();
        exp_data_q.delete();
        exp_last_q.delete();
        got_data_q.delete();
        got_last_q.delete();
        got_int_q.delete();
        got_ready_q.delete();
        overflow_cnt = 0;
    endtask

    // three clock edges with reset low, output flags checked before release
    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        iq_valid_i   = 1'b0;
        dma_tready_i = 1'b1;
        reset_ni     = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        compare_flag("dma_tvalid_o", dma_tvalid_o, 1'b0);
        compare_flag("dma_tlast_o", dma_tlast_o, 1'b0);
        compare_flag("overflow_o", overflow_o, 1'b0);
        compare_flag("int_o", int_o, 1'b0);
        @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        clear_model();
        stim_idx = '0;
    endtask

    // header word, then the sample index of the first sample in 16-bit slices
    task automatic predict_header(input logic [nr_grid_pkg::BLK_EXP_LEN-1:0] blk_exp);
        logic [nr_grid_pkg::IQ_WIDTH-1:0] word;
        word = '0;
        word[nr_grid_pkg::BLK_EXP_LEN-1:0] = blk_exp;
        exp_data_q.push_back(word);
        exp_last_q.push_back(1'b0);
        for (int k = 0; k < dma_stream_pkg::TIMESTAMP_WORDS; k++) begin
            exp_data_q.push_back(stim_idx[k*nr_grid_pkg::IQ_WIDTH +: nr_grid_pkg::IQ_WIDTH]);
            exp_last_q.push_back(1'b0);
        end
    endtask

    // strobes one symbol, up to max_gap idle cycles after each sample
    task automatic drive_symbol(input logic [nr_grid_pkg::BLK_EXP_LEN-1:0] blk_exp,
                                input int max_gap);
        logic [31:0]                      rnd;
        logic [nr_grid_pkg::IQ_WIDTH-1:0] sample;
        int                               gap;
        for (int i = 0; i < nr_grid_pkg::SYMBOL_LEN; i++) begin
            rnd    = $random(seed);
            sample = rnd[nr_grid_pkg::IQ_WIDTH-1:0];
            rnd    = $random(seed);
            gap    = int'(rnd[7:0]) % (max_gap + 1);
            if (i == 0) begin
                predict_header(blk_exp);
            end
            exp_data_q.push_back(sample);
            exp_last_q.push_back(i == nr_grid_pkg::SYMBOL_LEN - 1);
            @(posedge clk_i);
            #1;
            iq_valid_i = 1'b1;
            iq_data_i  = sample;
            blk_exp_i  = blk_exp;
            stim_idx   = stim_idx + 64'd1;
            repeat (gap) begin
                @(posedge clk_i);
                #1;
                iq_valid_i = 1'b0;
            end
        end
    endtask

    task automatic end_input();
        @(posedge clk_i);
        #1;
        iq_valid_i = 1'b0;
    endtask

    task automatic wait_offered(input int count);
        while (got_data_q.size() < count) begin
            @(posedge clk_i);
        end
    endtask

    // offered words must match the prediction one for one
    task automatic check_stream(output int dropped);
        wait_offered(exp_data_q.size());
        repeat (8) @(posedge clk_i);
        compare_count("offered word count", got_data_q.size(), exp_data_q.size());
        dropped = 0;
        for (int i = 0; i < got_data_q.size() && i < exp_data_q.size(); i++) begin
            compare_word("dma_tdata_o", got_data_q[i], exp_data_q[i]);
            compare_flag("dma_tlast_o", got_last_q[i], exp_last_q[i]);
            compare_flag("int_o", got_int_q[i], exp_last_q[i]);
            if (!got_ready_q[i]) begin
                dropped++;
            end
        end
        compare_count("overflow_o pulses", overflow_cnt, dropped);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_single_symbol();
        int start;
        int dropped;
        start = errors;
        apply_reset();
        drive_symbol(8'h0c, 0);
        end_input();
        check_stream(dropped);
        report_test("single symbol", start);
    endtask

    task automatic test_back_to_back();
        int start;
        int dropped;
        start = errors;
        apply_reset();
        drive_symbol(8'h11, 0);
        drive_symbol(8'h22, 0);
        drive_symbol(8'h83, 0);
        drive_symbol(8'hf4, 0);
        end_input();
        check_stream(dropped);
        report_test("back-to-back symbols", start);
    endtask

    task automatic test_gapped_input();
        int start;
        int dropped;
        start = errors;
        apply_reset();
        drive_symbol(8'h07, 3);
        drive_symbol(8'h3e, 3);
        end_input();
        check_stream(dropped);
        report_test("gapped input", start);
    endtask

    task automatic test_dma_not_ready();
        int start;
        int dropped;
        start = errors;
        apply_reset();
        fork
            begin
                drive_symbol(8'h5a, 0);
                end_input();
            end
            begin
                // stall across the timestamp words
                wait_offered(3);
                @(posedge clk_i);
                #1;
                dma_tready_i = 1'b0;
                repeat (6) @(posedge clk_i);
                #1;
                dma_tready_i = 1'b1;
            end
        join
        check_stream(dropped);
        checks++;
        if (dropped == 0) begin
            errors++;
            $display("tready window missed the packet and no word was dropped");
        end
        report_test("DMA not ready", start);
    endtask

    task automatic test_reset_mid_packet();
        int start;
        int dropped;
        start = errors;
        apply_reset();
        drive_symbol(8'h33, 0);
        end_input();
        wait_offered(8);
        apply_reset();
        drive_symbol(8'h44, 0);
        end_input();
        check_stream(dropped);
        report_test("reset mid-packet", start);
    endtask

    initial begin
        reset_ni     = 1'b0;
        iq_data_i    = '0;
        iq_valid_i   = 1'b0;
        blk_exp_i    = '0;
        dma_tready_i = 1'b1;
        stim_idx     = '0;
        overflow_cnt = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;

        test_single_symbol();
        test_back_to_back();
        test_gapped_input();
        test_dma_not_ready();
        test_reset_mid_packet();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- grid_rx_top.f
rtl/nr_grid_pkg.sv
rtl/dma_stream_pkg.sv
rtl/stream_fifo.sv
rtl/symbol_framer.sv
rtl/grid_subscriber.sv
rtl/grid_rx_top.sv
bench/grid_rx_checker.sv
bench/grid_rx_tb.sv

//--- rtl/dma_stream_pkg.sv
/*
 * DMA output stream format
 * Timestamp width, its split into DMA words and the states of the
 * subscriber that serializes each symbol.
 */
package dma_stream_pkg;

    // sample index recorded at the first sample of each symbol
    localparam int SAMPLE_ID_WIDTH = 64;

    // timestamp goes out least significant word first
    localparam int TIMESTAMP_WORDS = SAMPLE_ID_WIDTH / nr_grid_pkg::IQ_WIDTH;
    localparam int STAMP_CNT_WIDTH = $clog2(TIMESTAMP_WORDS);
    localparam logic [STAMP_CNT_WIDTH-1:0] LAST_STAMP_WORD =
        STAMP_CNT_WIDTH'(TIMESTAMP_WORDS - 1);

    // header, timestamp words, then IQ payload
    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_stamp,
        st_forward
    } subscriber_state_e;

endpackage

//--- rtl/grid_rx_top.sv
/*
 * Grid receive path
 * Framer, grid and timestamp FIFOs and the DMA subscriber between the
 * OFDM demodulator output and the DMA stream.
 */
module grid_rx_top (
    input  logic                                 clk_i,
    input  logic                                 reset_ni,

    input  logic [nr_grid_pkg::IQ_WIDTH-1:0]     iq_data_i,
    input  logic                                 iq_valid_i,
    input  logic [nr_grid_pkg::BLK_EXP_LEN-1:0]  blk_exp_i,

    input  logic                                 dma_tready_i,
    output logic [nr_grid_pkg::IQ_WIDTH-1:0]     dma_tdata_o,
    output logic                                 dma_tvalid_o,
    output logic                                 dma_tlast_o,

    output logic                                 overflow_o,
    output logic                                 int_o
);

    logic                                       grid_wr;
    logic [nr_grid_pkg::GRID_ENTRY_WIDTH-1:0]   grid_wr_data;
    logic                                       grid_valid;
    logic [nr_grid_pkg::GRID_ENTRY_WIDTH-1:0]   grid_data;
    logic                                       grid_ack;

    logic                                       id_wr;
    logic [dma_stream_pkg::SAMPLE_ID_WIDTH-1:0] id_wr_data;
    logic                                       id_valid;
    logic [dma_stream_pkg::SAMPLE_ID_WIDTH-1:0] id_data;
    logic                                       id_ack;

    symbol_framer framer (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .iq_data_i   (iq_data_i),
        .iq_valid_i  (iq_valid_i),
        .blk_exp_i   (blk_exp_i),
        .grid_wr_o   (grid_wr),
        .grid_data_o (grid_wr_data),
        .id_wr_o     (id_wr),
        .id_data_o   (id_wr_data)
    );

    stream_fifo #(
        .WIDTH (nr_grid_pkg::GRID_ENTRY_WIDTH),
        .DEPTH (nr_grid_pkg::GRID_FIFO_DEPTH)
    ) grid_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_i       (grid_wr),
        .wr_data_i  (grid_wr_data),
        .rd_ack_i   (grid_ack),
        .rd_valid_o (grid_valid),
        .rd_data_o  (grid_data)
    );

    stream_fifo #(
        .WIDTH (dma_stream_pkg::SAMPLE_ID_WIDTH),
        .DEPTH (nr_grid_pkg::ID_FIFO_DEPTH)
    ) id_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_i       (id_wr),
        .wr_data_i  (id_wr_data),
        .rd_ack_i   (id_ack),
        .rd_valid_o (id_valid),
        .rd_data_o  (id_data)
    );

    grid_subscriber subscriber (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .grid_valid_i (grid_valid),
        .grid_data_i  (grid_data),
        .grid_ack_o   (grid_ack),
        .id_valid_i   (id_valid),
        .id_data_i    (id_data),
        .id_ack_o     (id_ack),
        .dma_tready_i (dma_tready_i),
        .dma_tdata_o  (dma_tdata_o),
        .dma_tvalid_o (dma_tvalid_o),
        .dma_tlast_o  (dma_tlast_o),
        .overflow_o   (overflow_o),
        .int_o        (int_o)
    );

endmodule

//--- rtl/grid_subscriber.sv
/*
 * Grid subscriber
 * Serializes each buffered symbol towards the DMA: a header with the
 * block exponent, the 64-bit timestamp in IQ-wide words, then the IQ
 * samples with tlast on the final one. Raises an interrupt per symbol
 * and reports words offered while the DMA was not ready.
 */
module grid_subscriber (
    input  logic                                          clk_i,
    input  logic                                          reset_ni,

    // grid FIFO head
    input  logic                                          grid_valid_i,
    input  logic [nr_grid_pkg::GRID_ENTRY_WIDTH-1:0]      grid_data_i,
    output logic                                          grid_ack_o,

    // timestamp FIFO head
    input  logic                                          id_valid_i,
    input  logic [dma_stream_pkg::SAMPLE_ID_WIDTH-1:0]    id_data_i,
    output logic                                          id_ack_o,

    // DMA stream
    input  logic                                          dma_tready_i,
    output logic [nr_grid_pkg::IQ_WIDTH-1:0]              dma_tdata_o,
    output logic                                          dma_tvalid_o,
    output logic                                          dma_tlast_o,

    output logic                                          overflow_o,
    output logic                                          int_o
);

    dma_stream_pkg::subscriber_state_e state;

    logic [dma_stream_pkg::STAMP_CNT_WIDTH-1:0] stamp_cnt;
    logic [dma_stream_pkg::SAMPLE_ID_WIDTH-1:0] stamp_buf;

    logic [nr_grid_pkg::IQ_WIDTH-1:0]    head_iq;
    logic                                head_last;
    logic [nr_grid_pkg::BLK_EXP_LEN-1:0] head_exp;

    assign head_iq   = grid_data_i[nr_grid_pkg::IQ_WIDTH-1:0];
    assign head_last = grid_data_i[nr_grid_pkg::LAST_BIT];
    assign head_exp  = grid_data_i[nr_grid_pkg::EXP_LSB +: nr_grid_pkg::BLK_EXP_LEN];

    // pop every grid entry that gets forwarded
    assign grid_ack_o = (state == dma_stream_pkg::st_forward) && grid_valid_i;

    // timestamp leaves the FIFO once its last word is on the way out
    assign id_ack_o = (state == dma_stream_pkg::st_stamp)
                   && (stamp_cnt == dma_stream_pkg::LAST_STAMP_WORD);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state        <= dma_stream_pkg::st_idle;
            stamp_cnt    <= '0;
            dma_tvalid_o <= 1'b0;
            dma_tlast_o  <= 1'b0;
            int_o        <= 1'b0;
        end else begin
            dma_tvalid_o <= 1'b0;
            dma_tlast_o  <= 1'b0;
            int_o        <= 1'b0;
            case (state)
                dma_stream_pkg::st_idle: begin
                    // header carries the exponent of the symbol's first sample
                    if (grid_valid_i) begin
                        dma_tdata_o <= {{(nr_grid_pkg::IQ_WIDTH - nr_grid_pkg::BLK_EXP_LEN){1'b0}},
                                        head_exp};
                        dma_tvalid_o <= 1'b1;
                        state        <= dma_stream_pkg::st_header;
                    end
                end
                dma_stream_pkg::st_header: begin
                    if (id_valid_i) begin
                        dma_tdata_o  <= id_data_i[nr_grid_pkg::IQ_WIDTH-1:0];
                        stamp_buf    <= id_data_i >> nr_grid_pkg::IQ_WIDTH;
                        stamp_cnt    <= '0;
                        dma_tvalid_o <= 1'b1;
                        state        <= dma_stream_pkg::st_stamp;
                    end
                end
                dma_stream_pkg::st_stamp: begin
                    stamp_cnt <= stamp_cnt + 1'b1;
                    if (stamp_cnt == dma_stream_pkg::LAST_STAMP_WORD) begin
                        // one idle cycle while the first grid entry is fetched
                        state <= dma_stream_pkg::st_forward;
                    end else begin
                        dma_tdata_o  <= stamp_buf[nr_grid_pkg::IQ_WIDTH-1:0];
                        stamp_buf    <= stamp_buf >> nr_grid_pkg::IQ_WIDTH;
                        dma_tvalid_o <= 1'b1;
                    end
                end
                dma_stream_pkg::st_forward: begin
                    if (grid_valid_i) begin
                        dma_tdata_o  <= head_iq;
                        dma_tvalid_o <= 1'b1;
                        if (head_last) begin
                            dma_tlast_o <= 1'b1;
                            int_o       <= 1'b1;
                            state       <= dma_stream_pkg::st_idle;
                        end
                    end
                end
                default: state <= dma_stream_pkg::st_idle;
            endcase
        end
    end

    // a word offered without ready is lost, flag it one cycle later
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= dma_tvalid_o && !dma_tready_i;
        end
    end

endmodule

//--- rtl/nr_grid_pkg.sv
/*
 * Resource-grid input constants
 * Sample and exponent widths, symbol length and FIFO depths of the
 * demodulator side, plus the packing of one grid FIFO entry.
 */
package nr_grid_pkg;

    // one IQ sample, also the width of one DMA word
    localparam int IQ_WIDTH = 16;

    // block exponent delivered with every sample
    localparam int BLK_EXP_LEN = 8;

    // samples per OFDM symbol, kept small for short simulations
    localparam int SYMBOL_LEN = 16;

    // grid FIFO holds four whole symbols
    localparam int GRID_FIFO_DEPTH = 64;

    // one timestamp per buffered symbol
    localparam int ID_FIFO_DEPTH = 4;

    // sample-within-symbol counter
    localparam int SYMBOL_CNT_WIDTH = $clog2(SYMBOL_LEN);
    localparam logic [SYMBOL_CNT_WIDTH-1:0] LAST_SAMPLE = SYMBOL_CNT_WIDTH'(SYMBOL_LEN - 1);

    // grid entry layout, LSB first: IQ sample, last flag, block exponent
    localparam int LAST_BIT = IQ_WIDTH;
    localparam int EXP_LSB = IQ_WIDTH + 1;
    localparam int GRID_ENTRY_WIDTH = IQ_WIDTH + 1 + BLK_EXP_LEN;

endpackage

//--- rtl/stream_fifo.sv
/*
 * Stream FIFO
 * Synchronous first-word-fall-through buffer. The head entry is
 * presented without read delay and popped by a one-cycle acknowledge.
 * Writes that find the buffer full are discarded.
 */
module stream_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             reset_ni,

    input  logic             wr_i,
    input  logic [WIDTH-1:0] wr_data_i,

    input  logic             rd_ack_i,
    output logic             rd_valid_o,
    output logic [WIDTH-1:0] rd_data_o
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(DEPTH - 1);
    localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH + 1)'(DEPTH);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 full;
    logic                 do_write;
    logic                 do_read;

    assign full     = (count == FULL_COUNT);
    assign do_write = wr_i && !full;
    assign do_read  = rd_ack_i && rd_valid_o;

    // head is visible as soon as the count is non-zero
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the occupancy unchanged
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/symbol_framer.sv
/*
 * Symbol framer
 * Cuts the demodulator sample strobes into fixed-length symbols. Every
 * sample is pushed to the grid FIFO with its exponent and a last flag;
 * the first sample of a symbol also pushes the running sample index
 * as the symbol's timestamp.
 */
module symbol_framer (
    input  logic                                          clk_i,
    input  logic                                          reset_ni,

    // demodulator side, one strobe per sample
    input  logic [nr_grid_pkg::IQ_WIDTH-1:0]              iq_data_i,
    input  logic                                          iq_valid_i,
    input  logic [nr_grid_pkg::BLK_EXP_LEN-1:0]           blk_exp_i,

    // grid FIFO write side
    output logic                                          grid_wr_o,
    output logic [nr_grid_pkg::GRID_ENTRY_WIDTH-1:0]      grid_data_o,

    // timestamp FIFO write side
    output logic                                          id_wr_o,
    output logic [dma_stream_pkg::SAMPLE_ID_WIDTH-1:0]    id_data_o
);

    logic [nr_grid_pkg::SYMBOL_CNT_WIDTH-1:0]   sample_cnt;
    logic [dma_stream_pkg::SAMPLE_ID_WIDTH-1:0] sample_idx;
    logic                                       last_sample;
    logic                                       first_sample;

    assign last_sample  = (sample_cnt == nr_grid_pkg::LAST_SAMPLE);
    assign first_sample = (sample_cnt == '0);

    // position within the symbol and samples accepted since reset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt <= '0;
            sample_idx <= '0;
        end else if (iq_valid_i) begin
            sample_cnt <= last_sample ? '0 : sample_cnt + 1'b1;
            sample_idx <= sample_idx + 1'b1;
        end
    end

    // write strobes follow the input strobe by one cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            grid_wr_o <= 1'b0;
            id_wr_o   <= 1'b0;
        end else begin
            grid_wr_o <= iq_valid_i;
            id_wr_o   <= iq_valid_i && first_sample;
        end
    end

    // payload registers only load on a strobe
    always_ff @(posedge clk_i) begin
        if (iq_valid_i) begin
            grid_data_o <= {blk_exp_i, last_sample, iq_data_i};
            if (first_sample) begin
                id_data_o <= sample_idx;
            end
        end
    end

endmodule
